//--- rv_mem_defines.svh
`ifndef RV_MEM_DEFINES_SVH
`define RV_MEM_DEFINES_SVH

// datapath width
`define XLEN      32

// byte address width
`define ADDR_W    32

// data RAM depth in 32-bit words
`define RAM_WORDS 256

`endif

//--- rv_mem_pkg.sv
package rv_mem_pkg;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE,
        MEM_ATOMIC
    } mem_op_e;

    // A extension sub-ops
    typedef enum logic [3:0] {
        AMO_LR,
        AMO_SC,
        AMO_SWAP,
        AMO_ADD,
        AMO_XOR,
        AMO_AND,
        AMO_OR,
        AMO_MIN,
        AMO_MAX,
        AMO_MINU,
        AMO_MAXU
    } amo_op_e;

    typedef enum logic [1:0] {
        SIZE_B,
        SIZE_H,
        SIZE_W
    } mem_size_e;

    typedef enum logic {
        SGN_SIGNED,
        SGN_UNSIGNED
    } sign_e;

    typedef enum logic {
        ERR_ACCESS,
        ERR_MISALIGN
    } mem_err_e;

    // mcause codes, store covers AMO and SC
    typedef enum logic [3:0] {
        CAUSE_LOAD_MISALIGN  = 4'd4,
        CAUSE_LOAD_ACCESS    = 4'd5,
        CAUSE_STORE_MISALIGN = 4'd6,
        CAUSE_STORE_ACCESS   = 4'd7
    } trap_cause_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_READY,
        ST_WAIT_READ,
        ST_WAIT_WRITE
    } stage_state_e;

endpackage

//--- amo_alu.sv
`include "rv_mem_defines.svh"

module amo_alu (
    input  rv_mem_pkg::amo_op_e amo_op,
    input  logic [`XLEN-1:0]    old_data,
    input  logic [`XLEN-1:0]    rs2_data,
    output logic [`XLEN-1:0]    wdata
);
    import rv_mem_pkg::*;

    logic lt_s;
    logic lt_u;

    assign lt_s = $signed(old_data) < $signed(rs2_data);
    assign lt_u = old_data < rs2_data;

    always_comb begin
        case (amo_op)
            AMO_SWAP, AMO_SC: wdata = rs2_data;
            AMO_ADD:  wdata = old_data + rs2_data;
            AMO_XOR:  wdata = old_data ^ rs2_data;
            AMO_AND:  wdata = old_data & rs2_data;
            AMO_OR:   wdata = old_data | rs2_data;
            AMO_MIN:  wdata = lt_s ? old_data : rs2_data;
            AMO_MAX:  wdata = lt_s ? rs2_data : old_data;
            AMO_MINU: wdata = lt_u ? old_data : rs2_data;
            AMO_MAXU: wdata = lt_u ? rs2_data : old_data;
            default:  wdata = rs2_data; // LR never writes
        endcase
    end

endmodule

//--- load_align.sv
`include "rv_mem_defines.svh"

module load_align (
    input  rv_mem_pkg::mem_op_e   mem_op,
    input  rv_mem_pkg::amo_op_e   amo_op,
    input  rv_mem_pkg::mem_size_e mem_size,
    input  rv_mem_pkg::sign_e     sign,
    input  logic [1:0]            addr_lo,
    input  logic [`XLEN-1:0]      mem_data,
    input  logic                  sc_ok,
    output logic [`XLEN-1:0]      rdata
);
    import rv_mem_pkg::*;

    logic [`XLEN-1:0] lane;
    logic             sext;

    assign lane = mem_data >> {addr_lo, 3'b000}; // addressed lane to bit 0
    assign sext = (sign == SGN_SIGNED);

    always_comb begin
        rdata = '0;
        case (mem_op)
            MEM_LOAD: begin
                case (mem_size)
                    SIZE_B:  rdata = {{(`XLEN-8){sext & lane[7]}}, lane[7:0]};
                    SIZE_H:  rdata = {{(`XLEN-16){sext & lane[15]}}, lane[15:0]};
                    default: rdata = mem_data;
                endcase
            end
            MEM_ATOMIC: begin
                if (amo_op == AMO_SC)
                    rdata = {{(`XLEN-1){1'b0}}, ~sc_ok}; // 0 on success
                else
                    rdata = mem_data; // LR and AMOs return the old word
            end
            default: rdata = '0;
        endcase
    end

endmodule

//--- reservation_reg.sv
`include "rv_mem_defines.svh"

module reservation_reg (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               set,
    input  logic [`ADDR_W-1:0] set_addr,
    input  logic               clear,
    input  logic [`ADDR_W-1:0] cmp_addr,
    output logic               match
);

    logic               resv_valid;
    logic [`ADDR_W-3:0] resv_word;

    always_ff @(posedge clk) begin
        if (!rst_n)
            resv_valid <= 1'b0;
        else if (set)
            resv_valid <= 1'b1; // set wins over clear
        else if (clear)
            resv_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (set)
            resv_word <= set_addr[`ADDR_W-1:2];
    end

    // word granularity
    assign match = resv_valid && (resv_word == cmp_addr[`ADDR_W-1:2]);

endmodule

//--- memory_stage.sv
`include "rv_mem_defines.svh"

module memory_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    valid,
    input  logic                    is_new,
    input  rv_mem_pkg::mem_op_e     mem_op,
    input  rv_mem_pkg::amo_op_e     amo_op,
    input  rv_mem_pkg::mem_size_e   mem_size,
    input  rv_mem_pkg::sign_e       sign,
    input  logic [`ADDR_W-1:0]      addr,
    input  logic [`XLEN-1:0]        rs2_data,
    output logic                    stall,
    output logic [`XLEN-1:0]        rdata,
    output logic                    trap_valid,
    output rv_mem_pkg::trap_cause_e trap_cause,
    output logic                    req_valid,
    output logic                    req_write,
    output logic [`ADDR_W-1:0]      req_addr,
    output logic [`XLEN-1:0]        req_wdata,
    output rv_mem_pkg::mem_size_e   req_size,
    input  logic                    req_ready,
    input  logic                    resp_valid,
    input  logic [`XLEN-1:0]        resp_rdata,
    input  logic                    resp_error,
    input  rv_mem_pkg::mem_err_e    resp_err_kind
);
    import rv_mem_pkg::*;

    stage_state_e     state;
    logic             done;
    logic             amo_wr;   // AMO in its write phase
    logic             sc_ok;
    logic             err_flag;
    mem_err_e         err_kind;
    logic [`XLEN-1:0] saved_rdata;
    logic [`XLEN-1:0] amo_wdata;
    logic             resv_set;
    logic             resv_match;

    wire op_active = valid && (mem_op != MEM_NONE);
    wire is_atomic = (mem_op == MEM_ATOMIC);
    wire is_lr     = is_atomic && (amo_op == AMO_LR);
    wire is_sc     = is_atomic && (amo_op == AMO_SC);
    wire is_amo    = is_atomic && !is_lr && !is_sc;
    wire is_store  = (mem_op == MEM_STORE) || (is_atomic && !is_lr);
    wire pending   = is_new || !done;
    wire start     = (state == ST_IDLE) && op_active && pending;

    assign stall = op_active && pending;

    assign req_valid = valid && (state == ST_WAIT_READY);
    assign req_write = (mem_op == MEM_STORE) || is_sc || amo_wr;
    assign req_addr  = addr;
    assign req_wdata = is_atomic ? amo_wdata : rs2_data;
    assign req_size  = is_atomic ? SIZE_W : mem_size;

    assign resv_set   = valid && is_lr && (state == ST_WAIT_READ) && resp_valid && !resp_error;
    assign trap_valid = valid && done && !is_new && err_flag;

    always_comb begin
        if (err_kind == ERR_MISALIGN)
            trap_cause = is_store ? CAUSE_STORE_MISALIGN : CAUSE_LOAD_MISALIGN;
        else
            trap_cause = is_store ? CAUSE_STORE_ACCESS : CAUSE_LOAD_ACCESS;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            done     <= 1'b0;
            amo_wr   <= 1'b0;
            sc_ok    <= 1'b0;
            err_flag <= 1'b0;
            err_kind <= ERR_ACCESS;
        end else begin
            if (!valid || is_new)
                done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        amo_wr   <= 1'b0;
                        err_flag <= 1'b0;
                        sc_ok    <= resv_match;
                        if (is_sc && !resv_match)
                            done <= 1'b1; // failed SC, no RAM access
                        else
                            state <= ST_WAIT_READY;
                    end
                end
                ST_WAIT_READY: begin
                    if (!valid)
                        state <= ST_IDLE;
                    else if (req_ready)
                        state <= req_write ? ST_WAIT_WRITE : ST_WAIT_READ;
                end
                ST_WAIT_READ: begin
                    if (resp_valid) begin
                        err_flag <= resp_error;
                        err_kind <= resp_err_kind;
                        if (valid && is_amo && !resp_error) begin
                            state  <= ST_WAIT_READY; // reissue as store
                            amo_wr <= 1'b1;
                        end else begin
                            state <= ST_IDLE;
                            done  <= valid;
                        end
                    end
                end
                default: begin
                    if (resp_valid) begin
                        err_flag <= resp_error;
                        err_kind <= resp_err_kind;
                        state    <= ST_IDLE;
                        amo_wr   <= 1'b0;
                        done     <= valid;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_WAIT_READ && resp_valid)
            saved_rdata <= resp_rdata;
    end

    reservation_reg reservation_reg_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .set      (resv_set),
        .set_addr (addr),
        .clear    (start && is_sc),
        .cmp_addr (addr),
        .match    (resv_match)
    );

    amo_alu amo_alu_inst (
        .amo_op   (amo_op),
        .old_data (saved_rdata),
        .rs2_data (rs2_data),
        .wdata    (amo_wdata)
    );

    load_align load_align_inst (
        .mem_op   (mem_op),
        .amo_op   (amo_op),
        .mem_size (mem_size),
        .sign     (sign),
        .addr_lo  (addr[1:0]),
        .mem_data (saved_rdata),
        .sc_ok    (sc_ok),
        .rdata    (rdata)
    );

endmodule

//--- data_ram.sv
`include "rv_mem_defines.svh"

module data_ram (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  logic                  req_write,
    input  logic [`ADDR_W-1:0]    req_addr,
    input  logic [`XLEN-1:0]      req_wdata,
    input  rv_mem_pkg::mem_size_e req_size,
    output logic                  resp_valid,
    output logic [`XLEN-1:0]      resp_rdata,
    output logic                  resp_error,
    output rv_mem_pkg::mem_err_e  resp_err_kind
);
    import rv_mem_pkg::*;

    localparam int IDX_W = $clog2(`RAM_WORDS);
    localparam logic [`ADDR_W-1:0] ADDR_LIMIT = 4 * `RAM_WORDS;

    logic [`XLEN-1:0]   mem [`RAM_WORDS];
    logic [1:0]         lat_q;
    logic               q_write;
    logic [`ADDR_W-1:0] q_addr;
    logic [`XLEN-1:0]   q_wdata;
    mem_size_e          q_size;
    logic               misalign;
    logic               bad;
    logic [IDX_W-1:0]   idx;
    logic [`XLEN-1:0]   old_word;
    logic [`XLEN-1:0]   merged;

    assign req_ready  = (lat_q == 2'b00); // busy for two cycles after accept
    assign resp_valid = lat_q[1];

    assign misalign = (q_size == SIZE_H && q_addr[0]) ||
                      (q_size == SIZE_W && q_addr[1:0] != 2'b00);
    assign bad      = misalign || (q_addr >= ADDR_LIMIT);
    assign idx      = q_addr[IDX_W+1:2];
    assign old_word = mem[idx];

    always_comb begin
        merged = old_word;
        case (q_size)
            SIZE_B:  merged[{q_addr[1:0], 3'b000} +: 8] = q_wdata[7:0];
            SIZE_H:  merged[{q_addr[1], 4'b0000} +: 16] = q_wdata[15:0];
            default: merged = q_wdata;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            lat_q <= 2'b00;
        else
            lat_q <= {lat_q[0], req_valid && req_ready};
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            q_write <= req_write;
            q_addr  <= req_addr;
            q_wdata <= req_wdata;
            q_size  <= req_size;
        end
        if (lat_q[0]) begin
            resp_error    <= bad;
            resp_err_kind <= misalign ? ERR_MISALIGN : ERR_ACCESS;
            resp_rdata    <= bad ? '0 : old_word;
            if (q_write && !bad)
                mem[idx] <= merged;
        end
    end

endmodule

//--- mem_subsys_top.sv
`include "rv_mem_defines.svh"

module mem_subsys_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    valid,
    input  logic                    is_new,
    input  rv_mem_pkg::mem_op_e     mem_op,
    input  rv_mem_pkg::amo_op_e     amo_op,
    input  rv_mem_pkg::mem_size_e   mem_size,
    input  rv_mem_pkg::sign_e       sign,
    input  logic [`ADDR_W-1:0]      addr,
    input  logic [`XLEN-1:0]        rs2_data,
    output logic                    stall,
    output logic [`XLEN-1:0]        rdata,
    output logic                    trap_valid,
    output rv_mem_pkg::trap_cause_e trap_cause
);
    import rv_mem_pkg::*;

    // request channel
    logic               req_valid;
    logic               req_ready;
    logic               req_write;
    logic [`ADDR_W-1:0] req_addr;
    logic [`XLEN-1:0]   req_wdata;
    mem_size_e          req_size;
    // response strobe
    logic               resp_valid;
    logic [`XLEN-1:0]   resp_rdata;
    logic               resp_error;
    mem_err_e           resp_err_kind;

    memory_stage memory_stage_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .valid         (valid),
        .is_new        (is_new),
        .mem_op        (mem_op),
        .amo_op        (amo_op),
        .mem_size      (mem_size),
        .sign          (sign),
        .addr          (addr),
        .rs2_data      (rs2_data),
        .stall         (stall),
        .rdata         (rdata),
        .trap_valid    (trap_valid),
        .trap_cause    (trap_cause),
        .req_valid     (req_valid),
        .req_write     (req_write),
        .req_addr      (req_addr),
        .req_wdata     (req_wdata),
        .req_size      (req_size),
        .req_ready     (req_ready),
        .resp_valid    (resp_valid),
        .resp_rdata    (resp_rdata),
        .resp_error    (resp_error),
        .resp_err_kind (resp_err_kind)
    );

    data_ram data_ram_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req_write     (req_write),
        .req_addr      (req_addr),
        .req_wdata     (req_wdata),
        .req_size      (req_size),
        .resp_valid    (resp_valid),
        .resp_rdata    (resp_rdata),
        .resp_error    (resp_error),
        .resp_err_kind (resp_err_kind)
    );

endmodule

//--- tb_mem_subsys.sv
`include "rv_mem_defines.svh"

module tb_mem_subsys;
    import rv_mem_pkg::*;

    localparam logic [`ADDR_W-1:0] RAND_BASE = 32'h100;  // 8 words for the random phase

    typedef struct packed {
        mem_op_e            op;
        amo_op_e            aop;
        mem_size_e          size;
        sign_e              sgn;
        logic [`ADDR_W-1:0] addr;
        logic [`XLEN-1:0]   data;
        logic [`XLEN-1:0]   exp_rdata;
        logic               exp_trap;
        trap_cause_e        exp_cause;
    } step_t;

    logic               clk;
    logic               rst_n;
    logic               valid;
    logic               is_new;
    mem_op_e            mem_op;
    amo_op_e            amo_op;
    mem_size_e          mem_size;
    sign_e              sign;
    logic [`ADDR_W-1:0] addr;
    logic [`XLEN-1:0]   rs2_data;
    logic               stall;
    logic [`XLEN-1:0]   rdata;
    logic               trap_valid;
    trap_cause_e        trap_cause;

    step_t            steps [0:63];
    int               num_steps;
    int               step_no;
    logic [`XLEN-1:0] ref_mem [0:7];

    mem_subsys_top mem_subsys_top_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .valid      (valid),
        .is_new     (is_new),
        .mem_op     (mem_op),
        .amo_op     (amo_op),
        .mem_size   (mem_size),
        .sign       (sign),
        .addr       (addr),
        .rs2_data   (rs2_data),
        .stall      (stall),
        .rdata      (rdata),
        .trap_valid (trap_valid),
        .trap_cause (trap_cause)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_rdata(logic [`XLEN-1:0] exp);
        if (rdata !== exp)
            abort_run($sformatf("Mismatch at %0t: step %0d rdata %h, expected %h",
                                $time, step_no, rdata, exp));
    endtask

    task automatic check_trap(logic exp_valid, rv_mem_pkg::trap_cause_e exp_cause);
        if (trap_valid !== exp_valid || (exp_valid && trap_cause !== exp_cause))
            abort_run($sformatf("Mismatch at %0t: step %0d trap %b cause %0d, expected %b cause %0d",
                                $time, step_no, trap_valid, trap_cause, exp_valid, exp_cause));
    endtask

    // AMO result per the ISA definitions
    function automatic logic [`XLEN-1:0] amo_model(amo_op_e op, logic [`XLEN-1:0] mem_word,
                                                   logic [`XLEN-1:0] src);
        logic signed [`XLEN-1:0] m_s;
        logic signed [`XLEN-1:0] s_s;
        m_s = mem_word;
        s_s = src;
        case (op)
            AMO_ADD:  return mem_word + src;
            AMO_XOR:  return mem_word ^ src;
            AMO_AND:  return mem_word & src;
            AMO_OR:   return mem_word | src;
            AMO_MIN:  return (m_s <= s_s) ? mem_word : src;
            AMO_MAX:  return (m_s >= s_s) ? mem_word : src;
            AMO_MINU: return (mem_word <= src) ? mem_word : src;
            AMO_MAXU: return (mem_word >= src) ? mem_word : src;
            default:  return src;
        endcase
    endfunction

    // pulse is_new then wait for stall to drop
    task automatic run_op(mem_op_e op, amo_op_e aop, mem_size_e sz, sign_e sg,
                          logic [`ADDR_W-1:0] a, logic [`XLEN-1:0] d);
        int cycles;
        @(posedge clk);
        valid    <= 1'b1;
        is_new   <= 1'b1;
        mem_op   <= op;
        amo_op   <= aop;
        mem_size <= sz;
        sign     <= sg;
        addr     <= a;
        rs2_data <= d;
        @(posedge clk);
        is_new <= 1'b0;
        cycles = 0;
        @(negedge clk);
        while (stall) begin
            cycles++;
            if (cycles >= 50)
                abort_run($sformatf("step %0d: stall never fell within 50 cycles", step_no));
            @(negedge clk);
        end
    endtask

    task automatic append_step(mem_op_e op, amo_op_e aop, mem_size_e sz, sign_e sg,
                               logic [`ADDR_W-1:0] a, logic [`XLEN-1:0] d,
                               logic [`XLEN-1:0] exp, logic tv, trap_cause_e tc);
        steps[num_steps].op        = op;
        steps[num_steps].aop       = aop;
        steps[num_steps].size      = sz;
        steps[num_steps].sgn       = sg;
        steps[num_steps].addr      = a;
        steps[num_steps].data      = d;
        steps[num_steps].exp_rdata = exp;
        steps[num_steps].exp_trap  = tv;
        steps[num_steps].exp_cause = tc;
        num_steps++;
    endtask

    task automatic store_step(mem_size_e sz, logic [`ADDR_W-1:0] a, logic [`XLEN-1:0] d);
        append_step(MEM_STORE, AMO_LR, sz, SGN_SIGNED, a, d, '0, 1'b0, CAUSE_LOAD_MISALIGN);
    endtask

    task automatic load_step(mem_size_e sz, sign_e sg, logic [`ADDR_W-1:0] a,
                             logic [`XLEN-1:0] exp);
        append_step(MEM_LOAD, AMO_LR, sz, sg, a, '0, exp, 1'b0, CAUSE_LOAD_MISALIGN);
    endtask

    task automatic amo_step(amo_op_e aop, logic [`ADDR_W-1:0] a, logic [`XLEN-1:0] d,
                            logic [`XLEN-1:0] exp);
        append_step(MEM_ATOMIC, aop, SIZE_W, SGN_SIGNED, a, d, exp, 1'b0, CAUSE_LOAD_MISALIGN);
    endtask

    task automatic fault_step(mem_op_e op, amo_op_e aop, mem_size_e sz,
                              logic [`ADDR_W-1:0] a, trap_cause_e tc);
        append_step(op, aop, sz, SGN_SIGNED, a, 32'h0000_0001, '0, 1'b1, tc);
    endtask

    task automatic build_table();
        num_steps = 0;
        // lanes and extension
        store_step(SIZE_W, 32'h10, 32'h8765_4321);
        store_step(SIZE_W, 32'h14, 32'h1122_3344);
        store_step(SIZE_H, 32'h16, 32'h1234_beef);
        store_step(SIZE_B, 32'h15, 32'h5555_5580);
        load_step(SIZE_W, SGN_SIGNED,   32'h14, 32'hbeef_8044);
        load_step(SIZE_H, SGN_SIGNED,   32'h16, 32'hffff_beef);
        load_step(SIZE_H, SGN_UNSIGNED, 32'h16, 32'h0000_beef);
        load_step(SIZE_H, SGN_SIGNED,   32'h14, 32'hffff_8044);
        load_step(SIZE_B, SGN_SIGNED,   32'h15, 32'hffff_ff80);
        load_step(SIZE_B, SGN_UNSIGNED, 32'h15, 32'h0000_0080);
        load_step(SIZE_B, SGN_SIGNED,   32'h14, 32'h0000_0044);
        load_step(SIZE_B, SGN_UNSIGNED, 32'h17, 32'h0000_00be);
        load_step(SIZE_B, SGN_SIGNED,   32'h13, 32'hffff_ff87);
        // AMO chain where each op returns the previous result
        store_step(SIZE_W, 32'h20, 32'h0000_000a);
        amo_step(AMO_ADD,  32'h20, 32'h0000_0005, 32'h0000_000a);
        load_step(SIZE_W, SGN_SIGNED, 32'h20, 32'h0000_000f);
        amo_step(AMO_XOR,  32'h20, 32'h0000_00ff, 32'h0000_000f);
        amo_step(AMO_AND,  32'h20, 32'h0000_003c, 32'h0000_00f0);
        amo_step(AMO_OR,   32'h20, 32'h0f00_0001, 32'h0000_0030);
        amo_step(AMO_SWAP, 32'h20, 32'hffff_fff0, 32'h0f00_0031);
        amo_step(AMO_MIN,  32'h20, 32'h0000_0005, 32'hffff_fff0);  // -16 stays
        amo_step(AMO_MINU, 32'h20, 32'h0000_0005, 32'hffff_fff0);
        amo_step(AMO_MAX,  32'h20, 32'hffff_ff00, 32'h0000_0005);  // 5 stays
        amo_step(AMO_MAXU, 32'h20, 32'hffff_ff00, 32'h0000_0005);
        load_step(SIZE_W, SGN_SIGNED, 32'h20, 32'hffff_ff00);
        // LR/SC
        store_step(SIZE_W, 32'h30, 32'h1111_1111);
        amo_step(AMO_SC, 32'h30, 32'h0000_0022, 32'h0000_0001);    // no reservation yet
        amo_step(AMO_LR, 32'h30, 32'h0, 32'h1111_1111);
        amo_step(AMO_SC, 32'h30, 32'h2222_2222, 32'h0000_0000);
        load_step(SIZE_W, SGN_SIGNED, 32'h30, 32'h2222_2222);
        amo_step(AMO_SC, 32'h30, 32'h3333_3333, 32'h0000_0001);
        load_step(SIZE_W, SGN_SIGNED, 32'h30, 32'h2222_2222);
        store_step(SIZE_W, 32'h34, 32'h4444_4444);
        amo_step(AMO_LR, 32'h34, 32'h0, 32'h4444_4444);
        amo_step(AMO_SC, 32'h30, 32'h5555_5555, 32'h0000_0001);    // other word reserved
        load_step(SIZE_W, SGN_SIGNED, 32'h30, 32'h2222_2222);
        // traps
        fault_step(MEM_LOAD, AMO_LR, SIZE_W, 32'h22, CAUSE_LOAD_MISALIGN);
        fault_step(MEM_STORE, AMO_LR, SIZE_H, 32'h21, CAUSE_STORE_MISALIGN);
        load_step(SIZE_W, SGN_SIGNED, 32'h20, 32'hffff_ff00);
        store_step(SIZE_W, 32'h00, 32'h5a5a_0001);
        fault_step(MEM_ATOMIC, AMO_ADD, SIZE_W, 32'h400, CAUSE_STORE_ACCESS);
        load_step(SIZE_W, SGN_SIGNED, 32'h00, 32'h5a5a_0001);       // 0x400 aliases word 0
        fault_step(MEM_LOAD, AMO_LR, SIZE_W, 32'h800, CAUSE_LOAD_ACCESS);
    endtask

    task automatic random_phase();
        logic [`XLEN-1:0]   src;
        logic [`ADDR_W-1:0] a;
        int                 idx;
        int                 kind;
        amo_op_e            aop;
        for (int i = 0; i < 8; i++) begin
            step_no = 1000 + i;
            ref_mem[i] = $urandom;
            run_op(MEM_STORE, AMO_LR, SIZE_W, SGN_SIGNED, RAND_BASE + 4 * i, ref_mem[i]);
            check_rdata('0);
        end
        for (int n = 0; n < 40; n++) begin
            step_no = 2000 + n;
            idx  = $urandom_range(7, 0);
            kind = $urandom_range(9, 0);  // 0 is a load and 1..9 map to SWAP..MAXU
            src  = $urandom;
            a    = RAND_BASE + 4 * idx;
            if (kind == 0) begin
                run_op(MEM_LOAD, AMO_LR, SIZE_W, SGN_SIGNED, a, '0);
                check_rdata(ref_mem[idx]);
            end else begin
                aop = amo_op_e'(kind + 1);
                run_op(MEM_ATOMIC, aop, SIZE_W, SGN_SIGNED, a, src);
                check_rdata(ref_mem[idx]);
                ref_mem[idx] = amo_model(aop, ref_mem[idx], src);
            end
            check_trap(1'b0, CAUSE_LOAD_MISALIGN);
        end
    endtask

    initial begin
        void'($urandom(32'had99));
        rst_n    = 1'b0;
        valid    = 1'b0;
        is_new   = 1'b0;
        mem_op   = MEM_NONE;
        amo_op   = AMO_LR;
        mem_size = SIZE_W;
        sign     = SGN_SIGNED;
        addr     = '0;
        rs2_data = '0;
        step_no  = 0;
        build_table();
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < num_steps; i++) begin
            step_no = i;
            run_op(steps[i].op, steps[i].aop, steps[i].size, steps[i].sgn,
                   steps[i].addr, steps[i].data);
            check_rdata(steps[i].exp_rdata);
            check_trap(steps[i].exp_trap, steps[i].exp_cause);
        end
        random_phase();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- sources.f
+incdir+.
rv_mem_pkg.sv
amo_alu.sv
load_align.sv
reservation_reg.sv
memory_stage.sv
data_ram.sv
mem_subsys_top.sv
tb_mem_subsys.sv
